//--- sim.f
design/qsim_pkg.sv
design/qsim_mac.sv
design/qsim_state_loader.sv
design/qsim_matrix_apply.sv
design/qsim_state_writer.sv
design/qsim_top.sv
tests/tb_clock.sv
tests/qsim_sva.sv
tests/tb_qsim.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the qsim testbench with Verilator

cd "$(dirname "$0")" || { echo "Cannot enter the project directory"; exit 1; }

build_log=build.log
sim_log=sim.log

if ! verilator --binary --timing --assert --top-module tb_qsim -Mdir obj_dir \
    -f sim.f > "$build_log" 2>&1; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_qsim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"

if grep -qF "tests failed" "$sim_log"; then
  echo "Simulation reported a failure, see $sim_log"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- tests/qsim_stimulus.txt
identity 1
00010000 fffe0000 00008000 12345678
00010000 00000000 00000000 00000000
00000000 00010000 00000000 00000000
00000000 00000000 00010000 00000000
00000000 00000000 00000000 00010000
00010000 fffe0000 00008000 12345678

general 1
00010000 00020000 ffff0000 00000003
00008000 ffff8000 00004000 00008000
00000000 00000000 00000000 ffff8000
00030000 00000000 00018000 00000000
00000001 00000001 00000001 00000000
ffff4001 fffffffe 00018000 00000002

chain3 3
00010000 00020000 00030000 00040000
00000000 00010000 00000000 00000000
00010000 00000000 00000000 00000000
00000000 00000000 00000000 00010000
00000000 00000000 00010000 00000000
00010000 00000000 00000000 00000000
00000000 ffff0000 00000000 00000000
00000000 00000000 00008000 00000000
00000000 00000000 00000000 00020000
00000000 00000000 00000000 00010000
00010000 00000000 00000000 00000000
00000000 00010000 00000000 00000000
00000000 00000000 00010000 00000000
00060000 00020000 ffff0000 00020000

zero_gates 0
00000001 ffffffff 7fffffff 80000000
00000001 ffffffff 7fffffff 80000000

two_gates 2
00040000 fffc0000 00000005 00010000
00008000 00000000 00000000 00000000
00000000 00008000 00000000 00000000
00000000 00000000 00008000 00000000
00000000 00000000 00000000 00008000
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
00008002 00008002 00008002 00008002

//--- tests/tb_qsim.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qsim import qsim_pkg::*; ();

  logic              clk;
  logic              reset_n;
  logic              dut_valid;
  logic              dut_ready;
  mem_rd_req_t       in_rd;
  logic [DATA_W-1:0] in_rd_data = '0;
  mem_rd_req_t       gate_rd;
  logic [DATA_W-1:0] gate_rd_data = '0;
  mem_wr_t           out_wr;

  // Memory models and write capture
  logic [DATA_W-1:0] in_mem   [0:(1<<ADDR_W)-1];
  logic [DATA_W-1:0] gate_mem [0:(1<<ADDR_W)-1];
  logic [ADDR_W-1:0] in_addr_q = '0;
  logic [ADDR_W-1:0] gate_addr_q = '0;
  logic [DATA_W-1:0] out_cap  [0:DIM-1];
  int                hits     [0:DIM-1] = '{default: 0};
  int                write_count = 0;
  logic [DATA_W-1:0] expected [0:DIM-1];
  integer            seed;

  tb_clock i_clock (.clk(clk));

  qsim_top i_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .dut_valid    (dut_valid),
    .dut_ready    (dut_ready),
    .in_rd        (in_rd),
    .in_rd_data   (in_rd_data),
    .gate_rd      (gate_rd),
    .gate_rd_data (gate_rd_data),
    .out_wr       (out_wr)
  );

  bind qsim_top qsim_sva i_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_ready (dut_ready),
    .out_wr    (out_wr)
  );

  // ----------------------------------------------------------------------
  // Memory models
  // ----------------------------------------------------------------------
  // Address held across an edge returns in the cycle after it
  always @(negedge clk) begin
    in_rd_data   = in_mem[in_addr_q];
    gate_rd_data = gate_mem[gate_addr_q];
    in_addr_q    = in_rd.addr;
    gate_addr_q  = gate_rd.addr;
    if (out_wr.en) begin
      write_count++;
      if (out_wr.addr < ADDR_W'(DIM)) begin
        out_cap[out_wr.addr[1:0]] = out_wr.data;
        hits[out_wr.addr[1:0]]++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [DATA_W-1:0] exp_val,
                             input logic [DATA_W-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Fail %s %s: expected %h, actual %h", test, what, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic wait_ready(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (dut_ready !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (dut_ready !== level) begin
      $display("Timeout while waiting for %s", what);
      abort_run();
    end
  endtask

  task automatic read_word(input int fd, output logic [ELEM_W-1:0] word);
    int code;
    code = $fscanf(fd, "%h", word);
    if (code != 1) begin
      $display("Stimulus file ended in the middle of a test case");
      abort_run();
    end
  endtask

  // Random background so stray reads give wrong results
  task automatic fill_memories();
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      in_mem[ADDR_W'(a)]   = {$random(seed), $random(seed)};
      gate_mem[ADDR_W'(a)] = {$random(seed), $random(seed)};
    end
  endtask

  task automatic load_case(input int fd, input int gate_num);
    logic [ELEM_W-1:0] word;
    fill_memories();
    in_mem[0][COUNT_W-1:0] = COUNT_W'(gate_num);
    for (int k = 0; k < DIM; k++) begin
      read_word(fd, word);
      in_mem[ADDR_W'(k + 1)][ELEM_W-1:0] = word;
    end
    // Matrix m, row r, column c at m*16 + r*4 + c
    for (int k = 0; k < 16 * gate_num; k++) begin
      read_word(fd, word);
      gate_mem[ADDR_W'(k)][ELEM_W-1:0] = word;
    end
    // Output word is the element sign-extended
    for (int k = 0; k < DIM; k++) begin
      read_word(fd, word);
      expected[2'(k)] = {{(DATA_W-ELEM_W){word[ELEM_W-1]}}, word};
    end
  endtask

  task automatic check_idle();
    wait_ready(1'b1, 20, "dut_ready high after reset");
    repeat (8) begin
      @(negedge clk);
      check_value("reset_idle", "dut_ready", DATA_W'(1), DATA_W'(dut_ready));
      check_value("reset_idle", "write count", DATA_W'(0), DATA_W'(write_count));
    end
  endtask

  task automatic run_job(input string test);
    int base_count;
    int base_hits [0:DIM-1];
    base_count = write_count;
    base_hits  = hits;
    wait_ready(1'b1, 100, {"dut_ready before the start of ", test});
    dut_valid = 1'b1;
    @(negedge clk);
    wait_ready(1'b0, 100, {"dut_ready low after the start of ", test});
    dut_valid = 1'b0;
    // Request while busy must be dropped
    @(negedge clk);
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    wait_ready(1'b1, 2000, {"dut_ready high at the end of ", test});
    for (int k = 0; k < DIM; k++) begin
      check_value(test, $sformatf("output %0d", k), expected[2'(k)], out_cap[2'(k)]);
      check_value(test, $sformatf("writes to address %0d", k), DATA_W'(1),
                  DATA_W'(hits[2'(k)] - base_hits[2'(k)]));
    end
    check_value(test, "total writes", DATA_W'(DIM), DATA_W'(write_count - base_count));
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int              fd;
    int              gate_num;
    int              case_count;
    logic [8*24-1:0] case_name;
    seed       = 32'hac62_a392;
    reset_n    = 1'b1;
    dut_valid  = 1'b0;
    case_count = 0;
    fd = $fopen("tests/qsim_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tests/qsim_stimulus.txt");
      abort_run();
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b0;
    check_idle();
    while ($fscanf(fd, "%s %h", case_name, gate_num) == 2) begin
      load_case(fd, gate_num);
      run_job($sformatf("%0s", case_name));
      case_count++;
    end
    $fclose(fd);
    check_value("stimulus", "case count", DATA_W'(5), DATA_W'(case_count));
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/qsim_sva.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_sva import qsim_pkg::*; (
  input logic    clk,
  input logic    reset_n,
  input logic    dut_ready,
  input mem_wr_t out_wr
);

  // Write enable is cleared by the first reset edge
  a_no_write_in_reset: assert property (
    @(posedge clk) $past(reset_n) |-> !out_wr.en
  ) else $error("output write enabled while reset is asserted");

  // Busy for the whole write burst
  a_busy_while_writing: assert property (
    @(posedge clk) disable iff (reset_n)
    out_wr.en |-> !dut_ready
  ) else $error("dut_ready high during an output write");

  // Burst addresses climb by one
  a_write_addr_step: assert property (
    @(posedge clk) disable iff (reset_n)
    (out_wr.en && $past(out_wr.en)) |->
      (out_wr.addr == ($past(out_wr.addr) + ADDR_W'(1)))
  ) else $error("output write address did not step by one");

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // 8 ns period
  always begin
    #4 clk = ~clk;
  end

endmodule

`default_nettype wire

//--- design/qsim_top.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_top import qsim_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              dut_valid,
  output logic              dut_ready,
  output mem_rd_req_t       in_rd,
  input  logic [DATA_W-1:0] in_rd_data,
  output mem_rd_req_t       gate_rd,
  input  logic [DATA_W-1:0] gate_rd_data,
  output mem_wr_t           out_wr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_APPLY,
    ST_WRITE
  } phase_t;

  phase_t             phase;
  logic               load_start;
  logic               load_done;
  logic               apply_start;
  logic               apply_done;
  logic               write_start;
  logic               write_done;
  logic [COUNT_W-1:0] gate_count;
  state_vec_t         init_state;
  state_vec_t         final_state;

  // ----------------------------------------------------------------------
  // Phase controller
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_n) begin
      phase       <= ST_IDLE;
      dut_ready   <= 1'b0;
      load_start  <= 1'b0;
      apply_start <= 1'b0;
      write_start <= 1'b0;
    end else begin
      load_start  <= 1'b0;
      apply_start <= 1'b0;
      write_start <= 1'b0;
      case (phase)
        ST_IDLE: begin
          if (dut_valid && dut_ready) begin
            phase      <= ST_LOAD;
            load_start <= 1'b1;
            dut_ready  <= 1'b0;
          end else begin
            dut_ready <= 1'b1;
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            phase       <= ST_APPLY;
            apply_start <= 1'b1;
          end
        end
        ST_APPLY: begin
          if (apply_done) begin
            phase       <= ST_WRITE;
            write_start <= 1'b1;
          end
        end
        ST_WRITE: begin
          // Ready again the edge after the last write
          if (write_done) begin
            phase     <= ST_IDLE;
            dut_ready <= 1'b1;
          end
        end
        default: phase <= ST_IDLE;
      endcase
    end
  end

  qsim_state_loader i_loader (
    .clk        (clk),
    .reset_n    (reset_n),
    .load_start (load_start),
    .in_rd      (in_rd),
    .in_rd_data (in_rd_data),
    .load_done  (load_done),
    .gate_count (gate_count),
    .init_state (init_state)
  );

  qsim_matrix_apply i_apply (
    .clk          (clk),
    .reset_n      (reset_n),
    .apply_start  (apply_start),
    .gate_count   (gate_count),
    .init_state   (init_state),
    .gate_rd      (gate_rd),
    .gate_rd_data (gate_rd_data),
    .apply_done   (apply_done),
    .final_state  (final_state)
  );

  qsim_state_writer i_writer (
    .clk         (clk),
    .reset_n     (reset_n),
    .write_start (write_start),
    .final_state (final_state),
    .out_wr      (out_wr),
    .write_done  (write_done)
  );

endmodule

`default_nettype wire

//--- design/qsim_state_writer.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_state_writer import qsim_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       write_start,
  input  state_vec_t final_state,
  output mem_wr_t    out_wr,
  output logic       write_done
);

  logic       active;
  logic [1:0] idx;
  elem_t      elem;

  assign elem = final_state[idx];

  always_ff @(posedge clk) begin
    if (reset_n) begin
      active     <= 1'b0;
      idx        <= '0;
      write_done <= 1'b0;
      out_wr.en  <= 1'b0;
    end else begin
      out_wr.en   <= active;
      out_wr.addr <= ADDR_W'(idx);
      out_wr.data <= {{(DATA_W-ELEM_W){elem[ELEM_W-1]}}, elem};
      // Done lines up with the final write
      write_done  <= active && (idx == 2'd3);
      if (write_start) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (active) begin
        idx <= idx + 2'd1;
        if (idx == 2'd3) begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/qsim_matrix_apply.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_matrix_apply import qsim_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               apply_start,
  input  logic [COUNT_W-1:0] gate_count,
  input  state_vec_t         init_state,
  output mem_rd_req_t        gate_rd,
  input  logic [DATA_W-1:0]  gate_rd_data,
  output logic               apply_done,
  output state_vec_t         final_state
);

  // Issue side
  logic               active;
  logic               wait_q;
  logic               issue;
  logic               last;
  logic [COUNT_W-1:0] mat;
  logic [1:0]         row;
  logic [1:0]         col;

  // Return side
  logic       rd_vld_q;
  logic [1:0] col_q;
  logic [1:0] row_q;
  logic       last_q;
  logic       row_done_q;
  logic [1:0] row_q2;
  logic       last_q2;
  logic       mat_done;

  state_vec_t      work;
  elem_t [DIM-2:0] next_vec;
  elem_t           gate_elem;
  elem_t           acc;

  // Hold issue while the previous matrix drains into work
  assign issue    = active && !wait_q;
  assign last     = (mat == gate_count - COUNT_W'(1));
  assign mat_done = row_done_q && (row_q2 == 2'd3);

  assign gate_rd.addr = {mat, row, col};
  assign gate_elem    = gate_rd_data[ELEM_W-1:0];
  assign final_state  = work;

  qsim_mac i_mac (
    .clk     (clk),
    .reset_n (reset_n),
    .clear   (col_q == 2'd0),
    .enable  (rd_vld_q),
    .a       (gate_elem),
    .b       (work[col_q]),
    .acc     (acc)
  );

  // ----------------------------------------------------------------------
  // Counters and handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_n) begin
      active     <= 1'b0;
      wait_q     <= 1'b0;
      mat        <= '0;
      row        <= '0;
      col        <= '0;
      rd_vld_q   <= 1'b0;
      row_done_q <= 1'b0;
      apply_done <= 1'b0;
    end else begin
      rd_vld_q   <= issue;
      row_done_q <= rd_vld_q && (col_q == 2'd3);
      // M of 0 finishes right away
      apply_done <= (apply_start && (gate_count == '0)) || (mat_done && last_q2);
      if (apply_start) begin
        active <= (gate_count != '0);
        wait_q <= 1'b0;
        mat    <= '0;
        row    <= '0;
        col    <= '0;
      end else begin
        if (issue) begin
          col <= col + 2'd1;
          if (col == 2'd3) begin
            row <= row + 2'd1;
            if (row == 2'd3) begin
              if (last) begin
                active <= 1'b0;
              end else begin
                wait_q <= 1'b1;
                mat    <= mat + COUNT_W'(1);
              end
            end
          end
        end
        if (mat_done) begin
          wait_q <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Vector registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    col_q   <= col;
    row_q   <= row;
    last_q  <= last;
    row_q2  <= row_q;
    last_q2 <= last_q;
    if (row_done_q && (row_q2 != 2'd3)) begin
      next_vec[row_q2] <= acc;
    end
    // Row 3 comes straight from the accumulator
    if (apply_start) begin
      work <= init_state;
    end else if (mat_done) begin
      work <= {acc, next_vec};
    end
  end

endmodule

`default_nettype wire

//--- design/qsim_state_loader.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_state_loader import qsim_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               load_start,
  output mem_rd_req_t        in_rd,
  input  logic [DATA_W-1:0]  in_rd_data,
  output logic               load_done,
  output logic [COUNT_W-1:0] gate_count,
  output state_vec_t         init_state
);

  logic       active;
  logic [2:0] addr;
  logic       rd_vld_q;
  logic [2:0] rd_addr_q;
  logic [1:0] elem_idx;

  // Address 0 is M, addresses 1 to DIM are the elements
  assign in_rd.addr = ADDR_W'(addr);
  assign elem_idx   = 2'(rd_addr_q - 3'd1);

  // ----------------------------------------------------------------------
  // Read sequencing
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_n) begin
      active    <= 1'b0;
      addr      <= '0;
      rd_vld_q  <= 1'b0;
      load_done <= 1'b0;
    end else begin
      rd_vld_q  <= active;
      // Last word lands on the same edge
      load_done <= rd_vld_q && (rd_addr_q == 3'(DIM));
      if (load_start) begin
        active <= 1'b1;
        addr   <= '0;
      end else if (active) begin
        addr <= addr + 3'd1;
        if (addr == 3'(DIM)) begin
          active <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Capture of returning words
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    rd_addr_q <= addr;
    if (rd_vld_q) begin
      if (rd_addr_q == 3'd0) begin
        gate_count <= in_rd_data[COUNT_W-1:0];
      end else begin
        // Only the real half of the word is kept
        init_state[elem_idx] <= in_rd_data[ELEM_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/qsim_mac.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_mac import qsim_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  clear,
  input  logic  enable,
  input  elem_t a,
  input  elem_t b,
  output elem_t acc
);

  logic signed [2*ELEM_W-1:0] product;
  elem_t                      scaled;

  // Full width product, then back to Q16.16
  assign product = (2*ELEM_W)'(a) * (2*ELEM_W)'(b);
  assign scaled  = elem_t'(product >>> FRAC_W);

  always_ff @(posedge clk) begin
    if (reset_n) begin
      acc <= '0;
    end else if (enable) begin
      // Clear starts the next row with its first product
      if (clear) begin
        acc <= scaled;
      end else begin
        acc <= acc + scaled;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/qsim_pkg.sv
`default_nettype none

package qsim_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int DATA_W  = 64;
  localparam int ELEM_W  = 32;
  localparam int FRAC_W  = 16;
  localparam int DIM     = 4;
  localparam int ADDR_W  = 12;
  localparam int COUNT_W = 8;

  // ----------------------------------------------------------------------
  // Number format
  // ----------------------------------------------------------------------
  // Signed Q16.16
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Element 0 sits in the low bits
  typedef elem_t [DIM-1:0] state_vec_t;

  // ----------------------------------------------------------------------
  // Memory ports
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_wr_t;

endpackage

`default_nettype wire
